/* Bender.yml */
package:
  name: alu_pipe

sources:
  - files:
      - hdl/pipe_pkg.sv
      - hdl/register_file.sv
      - hdl/forwarding_unit.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/alu_pipe_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/alu_pipe_checker.sv
      - tb/alu_pipe_tb.sv

/* hdl/alu_pipe_top.sv */
// ========================================
// Pipeline top
// Decode, execute, memory and writeback with
// the forwarding unit and register file
// ========================================

`timescale 1ns/1ps

module alu_pipe_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            instr_valid,
  input  pipe_pkg::instr_u                instr,
  output logic                            instr_ready,
  output logic                            wb_valid,
  output logic [pipe_pkg::reg_addr_w-1:0] wb_rd,
  output logic [pipe_pkg::xlen-1:0]       wb_data,
  output logic                            br_valid,
  output logic                            br_taken
);

  import pipe_pkg::*;

  logic [reg_addr_w-1:0] rs1_addr, rs2_addr;
  logic [xlen-1:0]       rs1_data, rs2_data;
  logic [xlen-1:0]       ex_result, mem_result;
  id_fwd_e               id_forward_a, id_forward_b;
  ex_fwd_e               forward_a, forward_b;
  wr_port_t              ex_wr, mem_wr, wb_wr, idex_load_rd;
  idex_t                 idex;
  exmem_t                exmem;
  memwb_t                memwb;

  // Pending writes of the later stages
  assign mem_wr       = '{rd: exmem.rd, reg_write: exmem.reg_write};
  assign wb_wr        = '{rd: memwb.rd, reg_write: memwb.reg_write};
  assign idex_load_rd = '{rd: idex.rd, reg_write: idex.valid && idex.is_load && idex.reg_write};

  // Writeback port straight from MEM/WB
  assign wb_valid = memwb.valid && memwb.reg_write;
  assign wb_rd    = memwb.rd;
  assign wb_data  = memwb.result;

  register_file i_register_file (
    .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wr_en   (memwb.reg_write),
    .wr_addr (memwb.rd),
    .wr_data (memwb.result)
  );

  forwarding_unit i_forwarding_unit (
    .id_rs1       (rs1_addr),
    .id_rs2       (rs2_addr),
    .idex_rs1     (idex.rs1),
    .idex_rs2     (idex.rs2),
    .ex_wr, .mem_wr, .wb_wr,
    .idex_is_load (idex.valid && idex.is_load),
    .id_forward_a, .id_forward_b, .forward_a, .forward_b
  );

  decode_stage i_decode_stage (
    .clk, .reset, .instr_valid, .instr, .instr_ready,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .id_forward_a, .id_forward_b, .ex_result, .mem_result, .wb_data,
    .idex_load_rd, .idex, .br_valid, .br_taken
  );

  execute_stage i_execute_stage (
    .clk, .reset, .idex, .forward_a, .forward_b,
    .mem_result, .wb_data, .ex_result, .ex_wr, .exmem
  );

  memory_stage i_memory_stage (
    .clk, .reset, .exmem, .mem_result, .memwb
  );

endmodule

/* hdl/decode_stage.sv */
// ========================================
// Decode stage
// Decode, operand forwarding, branch compare,
// load-use stall and the ID/EX register
// ========================================

`timescale 1ns/1ps

module decode_stage (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            instr_valid,
  input  pipe_pkg::instr_u                instr,
  output logic                            instr_ready,
  output logic [pipe_pkg::reg_addr_w-1:0] rs1_addr,      // To register file
  output logic [pipe_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [pipe_pkg::xlen-1:0]       rs1_data,
  input  logic [pipe_pkg::xlen-1:0]       rs2_data,
  input  pipe_pkg::id_fwd_e               id_forward_a,
  input  pipe_pkg::id_fwd_e               id_forward_b,
  input  logic [pipe_pkg::xlen-1:0]       ex_result,     // Forwarded values
  input  logic [pipe_pkg::xlen-1:0]       mem_result,
  input  logic [pipe_pkg::xlen-1:0]       wb_data,
  input  pipe_pkg::wr_port_t              idex_load_rd,  // Load in EX
  output pipe_pkg::idex_t                 idex,
  output logic                            br_valid,
  output logic                            br_taken
);

  import pipe_pkg::*;

  logic            uses_rs1, uses_rs2;
  logic            writes, is_load, is_store, is_branch;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] src_a, src_b;
  logic            load_hazard;
  logic            accept;
  idex_t           idex_d;

  // Operand pick by one-hot select
  function automatic logic [xlen-1:0] id_mux(input id_fwd_e sel,
                                             input logic [xlen-1:0] rf,
                                             input logic [xlen-1:0] ex,
                                             input logic [xlen-1:0] mem,
                                             input logic [xlen-1:0] wb);
    case (sel)
      FWD_ID_EX:  return ex;
      FWD_ID_MEM: return mem;
      FWD_ID_WB:  return wb;
      default:    return rf;
    endcase
  endfunction

  // ========================================
  // Format decode by opcode
  // ========================================
  always_comb begin
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    imm       = '0;
    case (instr.r.op)
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        writes   = 1'b1;
      end
      ADDI, LW: begin  // I-format view
        uses_rs1 = 1'b1;
        writes   = 1'b1;
        is_load  = (instr.i.op == LW);
        imm      = {{(xlen-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};
      end
      SW: begin        // R-format, offset in funct
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        is_store = 1'b1;
        imm      = {{(xlen-funct_w){instr.r.funct[funct_w-1]}}, instr.r.funct};
      end
      BEQ, BNE: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        is_branch = 1'b1;
      end
      default: ;       // NOP
    endcase
  end

  // Unused sources read x0, which never forwards or stalls
  assign rs1_addr = uses_rs1 ? instr.r.rs1 : '0;
  assign rs2_addr = uses_rs2 ? instr.r.rs2 : '0;

  assign src_a = id_mux(id_forward_a, rs1_data, ex_result, mem_result, wb_data);
  assign src_b = id_mux(id_forward_b, rs2_data, ex_result, mem_result, wb_data);

  // Load data arrives one stage too late for decode
  assign load_hazard = instr_valid && idex_load_rd.reg_write && (idex_load_rd.rd != '0) &&
                       ((idex_load_rd.rd == rs1_addr) || (idex_load_rd.rd == rs2_addr));
  assign instr_ready = !load_hazard;
  assign accept      = instr_valid && instr_ready;

  // ========================================
  // ID/EX register, bubble when nothing accepted
  // ========================================
  always_comb begin
    idex_d           = '0;
    idex_d.valid     = accept;
    idex_d.op        = instr.r.op;
    idex_d.rd        = instr.r.rd;
    idex_d.rs1       = rs1_addr;
    idex_d.rs2       = rs2_addr;
    idex_d.reg_write = accept && writes && (instr.r.rd != '0);  // x0 writes vanish here
    idex_d.is_load   = accept && is_load;
    idex_d.is_store  = accept && is_store;
    idex_d.op_a      = src_a;
    idex_d.op_b      = src_b;
    idex_d.imm       = imm;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      idex.valid     <= 1'b0;
      idex.reg_write <= 1'b0;
      idex.is_load   <= 1'b0;
      idex.is_store  <= 1'b0;
    end else begin
      idex <= idex_d;
    end
  end

  // Branch outcome, reported one cycle after acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      br_valid <= 1'b0;
      br_taken <= 1'b0;
    end else begin
      br_valid <= accept && is_branch;
      br_taken <= accept && is_branch && ((instr.r.op == BNE) ^ (src_a == src_b));
    end
  end

endmodule

/* hdl/execute_stage.sv */
// ========================================
// Execute stage
// Operand forwarding, ALU and EX/MEM register
// ========================================

`timescale 1ns/1ps

module execute_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  pipe_pkg::idex_t           idex,
  input  pipe_pkg::ex_fwd_e         forward_a,
  input  pipe_pkg::ex_fwd_e         forward_b,
  input  logic [pipe_pkg::xlen-1:0] mem_result,
  input  logic [pipe_pkg::xlen-1:0] wb_data,
  output logic [pipe_pkg::xlen-1:0] ex_result,  // Also forwarded into decode
  output pipe_pkg::wr_port_t        ex_wr,
  output pipe_pkg::exmem_t          exmem
);

  import pipe_pkg::*;

  logic [xlen-1:0] a, b;

  // Latched operand unless MEM or WB holds something newer
  always_comb begin
    case (forward_a)
      FWD_EX_MEM: a = mem_result;
      FWD_EX_WB:  a = wb_data;
      default:    a = idex.op_a;
    endcase
    case (forward_b)
      FWD_EX_MEM: b = mem_result;
      FWD_EX_WB:  b = wb_data;
      default:    b = idex.op_b;
    endcase
  end

  // ========================================
  // ALU
  // ========================================
  always_comb begin
    case (idex.op)
      ALU_ADD:      ex_result = a + b;
      ALU_SUB:      ex_result = a - b;
      ALU_AND:      ex_result = a & b;
      ALU_OR:       ex_result = a | b;
      ALU_XOR:      ex_result = a ^ b;
      ADDI, LW, SW: ex_result = a + idex.imm;  // Sum or effective address
      default:      ex_result = '0;            // Branches and NOP write nothing
    endcase
  end

  assign ex_wr = '{rd: idex.rd, reg_write: idex.valid && idex.reg_write};

  always_ff @(posedge clk) begin
    if (reset) begin
      exmem.valid     <= 1'b0;
      exmem.reg_write <= 1'b0;
      exmem.is_load   <= 1'b0;
      exmem.is_store  <= 1'b0;
    end else begin
      exmem.valid      <= idex.valid;
      exmem.rd         <= idex.rd;
      exmem.reg_write  <= idex.valid && idex.reg_write;
      exmem.is_load    <= idex.valid && idex.is_load;
      exmem.is_store   <= idex.valid && idex.is_store;
      exmem.alu_result <= ex_result;
      exmem.store_data <= b;  // Store data already forwarded
    end
  end

endmodule

/* hdl/forwarding_unit.sv */
// ========================================
// Forwarding unit
// Compares ID and EX sources against pending
// writes and produces priority forward selects
// ========================================

`timescale 1ns/1ps

module forwarding_unit (
  input  logic [pipe_pkg::reg_addr_w-1:0] id_rs1,        // Decode sources
  input  logic [pipe_pkg::reg_addr_w-1:0] id_rs2,
  input  logic [pipe_pkg::reg_addr_w-1:0] idex_rs1,      // Execute sources
  input  logic [pipe_pkg::reg_addr_w-1:0] idex_rs2,
  input  pipe_pkg::wr_port_t              ex_wr,         // Instruction in EX
  input  pipe_pkg::wr_port_t              mem_wr,        // Instruction in MEM
  input  pipe_pkg::wr_port_t              wb_wr,         // Instruction in WB
  input  logic                            idex_is_load,  // EX result not ready yet
  output pipe_pkg::id_fwd_e               id_forward_a,
  output pipe_pkg::id_fwd_e               id_forward_b,
  output pipe_pkg::ex_fwd_e               forward_a,
  output pipe_pkg::ex_fwd_e               forward_b
);

  import pipe_pkg::*;

  // Pending write hits a source, x0 excluded
  function automatic logic hit(input wr_port_t wr, input logic [reg_addr_w-1:0] src);
    return wr.reg_write && (wr.rd != '0) && (wr.rd == src);
  endfunction

  // ========================================
  // ID select, EX > MEM > WB > register file
  // ========================================
  function automatic id_fwd_e id_select(input logic [reg_addr_w-1:0] src,
                                        input wr_port_t ex,
                                        input wr_port_t mem,
                                        input wr_port_t wb,
                                        input logic ex_is_load);
    if (hit(ex, src) && !ex_is_load) return FWD_ID_EX;  // Load data only exists in MEM
    if (hit(mem, src)) return FWD_ID_MEM;
    if (hit(wb, src)) return FWD_ID_WB;
    return FWD_ID_NONE;
  endfunction

  // ========================================
  // EX select, MEM > WB > latched operand
  // ========================================
  function automatic ex_fwd_e ex_select(input logic [reg_addr_w-1:0] src,
                                        input wr_port_t mem,
                                        input wr_port_t wb);
    if (hit(mem, src)) return FWD_EX_MEM;  // Most recent producer wins
    if (hit(wb, src)) return FWD_EX_WB;
    return FWD_EX_NONE;
  endfunction

  always_comb begin
    id_forward_a = id_select(id_rs1, ex_wr, mem_wr, wb_wr, idex_is_load);
    id_forward_b = id_select(id_rs2, ex_wr, mem_wr, wb_wr, idex_is_load);
  end

  always_comb begin
    forward_a = ex_select(idex_rs1, mem_wr, wb_wr);
    forward_b = ex_select(idex_rs2, mem_wr, wb_wr);
  end

endmodule

/* hdl/memory_stage.sv */
// ========================================
// Memory stage
// Word scratchpad for LW/SW and MEM/WB register
// ========================================

`timescale 1ns/1ps

module memory_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  pipe_pkg::exmem_t          exmem,
  output logic [pipe_pkg::xlen-1:0] mem_result,  // Load data or ALU result
  output pipe_pkg::memwb_t          memwb
);

  import pipe_pkg::*;

  localparam int idx_w = $clog2(spad_words);

  logic [xlen-1:0]  spad [spad_words];
  logic [idx_w-1:0] spad_idx;

  assign spad_idx = exmem.alu_result[2 +: idx_w];  // Word address, bits [5:2]

  // Scratchpad is cleared with the rest of the state
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < spad_words; i++) spad[i] <= '0;
    end else if (exmem.valid && exmem.is_store) begin
      spad[spad_idx] <= exmem.store_data;
    end
  end

  // Combinational load
  assign mem_result = exmem.is_load ? spad[spad_idx] : exmem.alu_result;

  // ========================================
  // MEM/WB register
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      memwb.valid     <= 1'b0;
      memwb.reg_write <= 1'b0;
    end else begin
      memwb.valid     <= exmem.valid;
      memwb.rd        <= exmem.rd;
      memwb.reg_write <= exmem.valid && exmem.reg_write;
      memwb.result    <= mem_result;
    end
  end

endmodule

/* hdl/pipe_pkg.sv */
// ========================================
// Pipeline package
// Opcodes, instruction formats, stage registers
// and the forward-select encodings
// ========================================

package pipe_pkg;

  localparam int xlen       = 32;  // Data word width
  localparam int reg_addr_w = 5;   // Register index width
  localparam int spad_words = 16;  // Scratchpad depth in words
  localparam int imm_w      = 18;  // I-format immediate
  localparam int funct_w    = 13;  // R-format funct, SW offset

  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ADDI    = 4'h5,
    LW      = 4'h6,
    SW      = 4'h7,
    BEQ     = 4'h8,
    BNE     = 4'h9,
    NOP     = 4'hf
  } opcode_e;

  // ========================================
  // Instruction word, two views of the same bits
  // ========================================
  typedef struct packed {
    opcode_e                 op;
    logic [reg_addr_w-1:0]   rd;
    logic [reg_addr_w-1:0]   rs1;
    logic [reg_addr_w-1:0]   rs2;
    logic [funct_w-1:0]      funct;  // Signed store offset for SW
  } r_fmt_t;

  typedef struct packed {
    opcode_e                 op;
    logic [reg_addr_w-1:0]   rd;
    logic [reg_addr_w-1:0]   rs1;
    logic signed [imm_w-1:0] imm;    // ADDI, LW
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  // One-hot ID select, EX > MEM > WB
  typedef enum logic [2:0] {
    FWD_ID_NONE = 3'b000,
    FWD_ID_EX   = 3'b100,
    FWD_ID_MEM  = 3'b010,
    FWD_ID_WB   = 3'b001
  } id_fwd_e;

  typedef enum logic [1:0] {
    FWD_EX_NONE = 2'b00,
    FWD_EX_WB   = 2'b01,
    FWD_EX_MEM  = 2'b10
  } ex_fwd_e;

  // Pending write of one stage
  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
  } wr_port_t;

  // ========================================
  // Stage registers
  // ========================================
  typedef struct packed {
    logic                  valid;
    opcode_e               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic                  reg_write;
    logic                  is_load;
    logic                  is_store;
    logic [xlen-1:0]       op_a;  // Operand values as seen in decode
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       imm;   // Sign extended
  } idex_t;

  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
    logic                  is_load;
    logic                  is_store;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;
  } exmem_t;

  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
    logic [xlen-1:0]       result;
  } memwb_t;

endpackage

/* hdl/register_file.sv */
// ========================================
// Integer register file
// 32 x 32, async read, x0 reads zero
// ========================================

`timescale 1ns/1ps

module register_file (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [pipe_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [pipe_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [pipe_pkg::xlen-1:0]       rs1_data,
  output logic [pipe_pkg::xlen-1:0]       rs2_data,
  input  logic                            wr_en,
  input  logic [pipe_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [pipe_pkg::xlen-1:0]       wr_data
);

  import pipe_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_w; i++) regs[i] <= '0;
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;  // x0 write dropped
    end
  end

  // No bypass here, decode forwards from WB
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* tb/alu_pipe_checker.sv */
// ========================================
// Pipeline checker
// Forward-select and stall properties,
// bound into the decode stage
// ========================================

`timescale 1ns/1ps

module alu_pipe_checker (
  input logic                            clk,
  input logic                            reset,
  input logic                            instr_ready,
  input logic [pipe_pkg::reg_addr_w-1:0] rs1_addr,
  input logic [pipe_pkg::reg_addr_w-1:0] rs2_addr,
  input pipe_pkg::id_fwd_e               id_forward_a,
  input pipe_pkg::id_fwd_e               id_forward_b
);

  import pipe_pkg::*;

  int unsigned fail_count = 0;  // Read by the testbench

  // One source at most per operand
  a_id_sel_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(id_forward_a) && $onehot0(id_forward_b))
    else begin
      $error("ID forward select is not one-hot or zero");
      fail_count++;
    end

  // x0 is never forwarded
  a_no_fwd_x0: assert property (@(posedge clk) disable iff (reset)
    ((rs1_addr != '0) || (id_forward_a == FWD_ID_NONE)) &&
    ((rs2_addr != '0) || (id_forward_b == FWD_ID_NONE)))
    else begin
      $error("Forward select active for source x0");
      fail_count++;
    end

  // Load-use stall lasts one cycle
  a_single_stall: assert property (@(posedge clk) disable iff (reset)
    !instr_ready |=> instr_ready)
    else begin
      $error("instr_ready low for two consecutive cycles");
      fail_count++;
    end

endmodule

/* tb/alu_pipe_tb.sv */
// ========================================
// Pipeline testbench
// Directed and random programs checked against
// an in-order reference model
// ========================================

`timescale 1ns/1ps

module alu_pipe_tb;

  import pipe_pkg::*;

  localparam int reset_cycles = 10;
  localparam int n_random     = 200;
  localparam int wd_per_instr = 40;   // Watchdog cycles per issued instruction

  typedef struct packed {
    logic [31:0]           due;      // Cycle the result must show up
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } wb_exp_t;

  typedef struct packed {
    logic [31:0] due;
    logic        taken;
  } br_exp_t;

  logic                  clk, reset;
  logic                  instr_valid, instr_ready;
  instr_u                instr;
  logic                  wb_valid, br_valid, br_taken;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  logic [xlen-1:0] model_regs [2**reg_addr_w];  // Reference state
  logic [xlen-1:0] model_spad [spad_words];
  wb_exp_t         wb_q [$];
  br_exp_t         br_q [$];
  logic [31:0]     cycle     = 0;
  int              issued    = 0;
  int              wd_cycles = 0;
  logic [31:0]     rng       = 32'hbcd660e5;
  int unsigned     assert_fails;

  tb_clock_gen i_tb_clock_gen (.clk, .reset);

  alu_pipe_top i_alu_pipe_top (
    .clk, .reset, .instr_valid, .instr, .instr_ready,
    .wb_valid, .wb_rd, .wb_data, .br_valid, .br_taken
  );

  bind decode_stage alu_pipe_checker i_alu_pipe_checker (
    .clk, .reset, .instr_ready, .rs1_addr, .rs2_addr, .id_forward_a, .id_forward_b
  );

  assign assert_fails = i_alu_pipe_top.i_decode_stage.i_alu_pipe_checker.fail_count;

  // ========================================
  // Helpers
  // ========================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic instr_u build_r(input opcode_e op, input int rd, input int rs1,
                                     input int rs2, input int funct);
    instr_u ins;
    ins         = '0;
    ins.r.op    = op;
    ins.r.rd    = rd[reg_addr_w-1:0];
    ins.r.rs1   = rs1[reg_addr_w-1:0];
    ins.r.rs2   = rs2[reg_addr_w-1:0];
    ins.r.funct = funct[funct_w-1:0];  // Store offset, two's complement
    return ins;
  endfunction

  function automatic instr_u build_i(input opcode_e op, input int rd, input int rs1,
                                     input int imm);
    instr_u ins;
    ins       = '0;
    ins.i.op  = op;
    ins.i.rd  = rd[reg_addr_w-1:0];
    ins.i.rs1 = rs1[reg_addr_w-1:0];
    ins.i.imm = imm[imm_w-1:0];
    return ins;
  endfunction

  function automatic opcode_e pick_op(input int k);
    case (k)
      0:       return ALU_ADD;
      1:       return ALU_SUB;
      2:       return ALU_AND;
      3:       return ALU_OR;
      4:       return ALU_XOR;
      5:       return ADDI;
      6:       return LW;
      7:       return SW;
      8:       return BEQ;
      9:       return BNE;
      default: return NOP;
    endcase
  endfunction

  // ========================================
  // Reference model, one call per accepted instruction
  // ========================================
  task automatic predict(input instr_u ins);
    logic [xlen-1:0] a, b, res, addr, imm_i, off_s;
    logic            wr;
    a     = model_regs[ins.r.rs1];
    b     = model_regs[ins.r.rs2];
    imm_i = {{(xlen-imm_w){ins.i.imm[imm_w-1]}}, ins.i.imm};
    off_s = {{(xlen-funct_w){ins.r.funct[funct_w-1]}}, ins.r.funct};
    wr    = 1'b1;
    res   = '0;
    case (ins.r.op)
      ALU_ADD: res = a + b;
      ALU_SUB: res = a - b;
      ALU_AND: res = a & b;
      ALU_OR:  res = a | b;
      ALU_XOR: res = a ^ b;
      ADDI:    res = a + imm_i;
      LW: begin
        addr = a + imm_i;
        res  = model_spad[addr[5:2]];  // Word index
      end
      SW: begin
        addr                  = a + off_s;
        model_spad[addr[5:2]] = b;
        wr                    = 1'b0;
      end
      BEQ, BNE: begin  // BEQ taken on equal, BNE on different
        br_q.push_back('{due: cycle + 1, taken: (ins.r.op == BEQ) ? (a == b) : (a != b)});
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (wr && (ins.r.rd != '0)) begin   // x0 writes are silent
      model_regs[ins.r.rd] = res;
      wb_q.push_back('{due: cycle + 3, rd: ins.r.rd, data: res});
    end
  endtask

  // ========================================
  // Compare tasks
  // ========================================
  task automatic compare_wb(input logic [reg_addr_w-1:0] rd, input logic [xlen-1:0] data);
    if ((wb_rd !== rd) || (wb_data !== data))
      abort_run($sformatf("FAILED at %0t: writeback x%0d = %08h, expected x%0d = %08h",
                          $time, wb_rd, wb_data, rd, data));
  endtask

  task automatic compare_branch(input logic taken);
    if (br_taken !== taken)
      abort_run($sformatf("FAILED at %0t: br_taken = %b, expected %b", $time, br_taken, taken));
  endtask

  task automatic compare_ready(input logic exp);
    if (instr_ready !== exp)
      abort_run($sformatf("FAILED at %0t: instr_ready = %b, expected %b",
                          $time, instr_ready, exp));
  endtask

  task automatic compare_stalls(input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("FAILED at %0t: %0d stall cycles, expected %0d", $time, got, exp));
  endtask

  // ========================================
  // Output monitor, sampled before the edge updates
  // ========================================
  always @(posedge clk) begin
    if (!reset) begin
      cycle = cycle + 1;
      if (assert_fails != 0) abort_run("An assertion in the bound checker failed");
      if ((wb_q.size() != 0) && (wb_q[0].due == cycle)) begin
        if (!wb_valid) abort_run($sformatf("Writeback of x%0d did not arrive on time", wb_q[0].rd));
        compare_wb(wb_q[0].rd, wb_q[0].data);
        void'(wb_q.pop_front());
      end else if (wb_valid) begin
        abort_run($sformatf("Writeback of x%0d was not expected at this time", wb_rd));
      end
      if ((br_q.size() != 0) && (br_q[0].due == cycle)) begin
        if (!br_valid) abort_run("Branch outcome did not arrive on time");
        compare_branch(br_q[0].taken);
        void'(br_q.pop_front());
      end else if (br_valid) begin
        abort_run("Branch outcome was reported without a branch");
      end
      if (instr_valid && instr_ready) begin  // Acceptance in program order
        issued++;
        predict(instr);
      end
    end
  end

  // Watchdog, budget grows with every accepted instruction
  always @(negedge clk) begin
    wd_cycles++;
    if (wd_cycles > reset_cycles + wd_per_instr * (issued + 1))
      abort_run("Watchdog timeout: the pipeline stopped making progress");
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic issue(input instr_u ins, output int stalls);
    stalls = 0;
    instr       <= ins;
    instr_valid <= 1'b1;
    @(posedge clk);
    while (!instr_ready) begin  // Held stable during the stall
      stalls++;
      @(posedge clk);
    end
  endtask

  task automatic send(input instr_u ins);
    int stalls;
    issue(ins, stalls);
  endtask

  task automatic idle(input int n);
    instr_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drain();
    instr_valid <= 1'b0;
    @(negedge clk);
    while ((wb_q.size() != 0) || (br_q.size() != 0)) @(negedge clk);
    @(posedge clk);
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_reset();
    repeat (5) begin            // Monitor flags any stray wb or branch
      compare_ready(1'b1);
      @(posedge clk);
    end
  endtask

  task automatic test_alu_chain();
    send(build_i(ADDI, 1, 0, 5));
    send(build_i(ADDI, 2, 1, 3));
    send(build_r(ALU_ADD, 3, 1, 2, 0));
    send(build_r(ALU_SUB, 4, 3, 1, 0));
    send(build_r(ALU_XOR, 5, 4, 3, 0));
    send(build_r(ALU_AND, 6, 5, 2, 0));
    send(build_r(ALU_OR, 7, 6, 4, 0));
    send(build_i(ADDI, 8, 7, -100));
    send(build_r(ALU_ADD, 8, 8, 8, 0));
    drain();
  endtask

  task automatic test_x0();
    send(build_i(ADDI, 0, 1, 77));      // Dropped write
    send(build_r(ALU_ADD, 9, 0, 0, 0));
    send(build_i(ADDI, 10, 0, 1));
    send(build_r(ALU_OR, 11, 0, 10, 0));
    drain();
  endtask

  task automatic test_load_store();
    int stalls;
    send(build_i(ADDI, 12, 0, 'h123));
    send(build_i(ADDI, 13, 0, 8));
    send(build_r(SW, 0, 13, 12, 4));    // spad[3]
    send(build_i(LW, 14, 13, 4));
    issue(build_r(ALU_ADD, 15, 14, 14, 0), stalls);
    compare_stalls(stalls, 1);
    send(build_r(SW, 0, 13, 15, -4));   // spad[1]
    send(build_i(LW, 16, 0, 4));
    issue(build_r(ALU_XOR, 17, 16, 12, 0), stalls);
    compare_stalls(stalls, 1);
    drain();
  endtask

  task automatic test_branch();
    int stalls;
    send(build_i(ADDI, 20, 0, 7));
    send(build_i(ADDI, 21, 0, 7));
    send(build_r(BEQ, 0, 20, 21, 0));   // Distance 1 and 2
    send(build_i(ADDI, 22, 0, 9));
    send(build_r(NOP, 0, 0, 0, 0));
    send(build_r(BNE, 0, 22, 20, 0));   // Distance 2
    send(build_i(ADDI, 23, 0, 9));
    send(build_r(NOP, 0, 0, 0, 0));
    send(build_r(NOP, 0, 0, 0, 0));
    send(build_r(BEQ, 0, 23, 22, 0));   // Distance 3
    send(build_i(ADDI, 25, 0, 3));
    send(build_i(ADDI, 24, 0, 1));
    send(build_i(ADDI, 24, 0, 2));
    send(build_i(ADDI, 24, 0, 3));
    send(build_r(BEQ, 0, 24, 25, 0));   // Newest x24 must win
    send(build_r(BNE, 0, 24, 25, 0));
    send(build_i(ADDI, 24, 0, 4));
    send(build_r(BNE, 0, 24, 25, 0));
    send(build_i(LW, 26, 0, 4));
    issue(build_r(BEQ, 0, 26, 15, 0), stalls);
    compare_stalls(stalls, 1);
    drain();
  endtask

  task automatic test_random();
    logic [31:0] r;
    instr_u      ins;
    for (int n = 0; n < n_random; n++) begin
      rng = xorshift(rng);
      r   = rng;
      ins = build_r(pick_op(r[7:0] % 11), r[10:8], r[13:11], r[16:14], 0);
      ins.i.imm = r[31:14];              // Overlays rs2 and funct
      if ((ins.r.op == SW) || (ins.r.op == BEQ) || (ins.r.op == BNE)) begin
        ins.r.rs2   = r[16:14];
        ins.r.funct = r[29:17];
      end
      send(ins);
      rng = xorshift(rng);
      if (rng[1:0] == 2'b00) idle(rng[3:2]);  // Gap in instr_valid
    end
    drain();
  endtask

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < 2**reg_addr_w; i++) model_regs[i] = '0;
    for (int i = 0; i < spad_words; i++) model_spad[i] = '0;
    @(posedge clk);
    while (reset) @(posedge clk);
    test_reset();
    test_alu_chain();
    test_x0();
    test_load_store();
    test_branch();
    test_random();
    if (assert_fails == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Checker assertions failed");
    end
  end

endmodule

/* tb/tb_clock_gen.sv */
// ========================================
// Testbench clock and reset
// 20 ns clock, reset held for 10 cycles
// ========================================

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;           // Released on a rising edge
  end

endmodule

/* vlog.f */
hdl/pipe_pkg.sv
hdl/register_file.sv
hdl/forwarding_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/alu_pipe_top.sv
tb/tb_clock_gen.sv
tb/alu_pipe_checker.sv
tb/alu_pipe_tb.sv
